// ==== execCore.f ====
logic/mipsPkg.sv
logic/instrDecoder.sv
logic/aluUnit.sv
logic/mulDivUnit.sv
logic/memAccess.sv
logic/execCore.sv
testbench/tbClock.sv
testbench/execCore_properties.sv
testbench/execCoreTb.sv

// ==== logic/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit import mipsPkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  aluOpT       aluOp,
	input  logic        cmpNe,
	output logic [31:0] result,
	output logic        cmpTrue
);

	logic sltRes;
	logic sltuRes;

	assign sltRes  = $signed(a) < $signed(b);
	assign sltuRes = a < b;

	always_comb begin
		case (aluOp)
			aluAdd: begin
				result = a + b;
			end
			aluSub: begin
				result = a - b;
			end
			aluOr: begin
				result = a | b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluLui: begin
				result = {b[15:0], 16'h0000};	// Immediate into upper half
			end
			aluSlt: begin
				result = {31'b0, sltRes};
			end
			aluSltu: begin
				result = {31'b0, sltuRes};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Branch test, b is rt for beq/bne
	assign cmpTrue = (a == b) ^ cmpNe;

endmodule

// ==== logic/execCore.sv ====
`timescale 1ns/100ps

module execCore import mipsPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        instrValid,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output wbT          wb,
	output logic        branchTaken,
	output npcOpT       npcSel,
	output logic        busy
);

	ctrlT        ctrl;
	logic [31:0] imm;
	logic [31:0] opB;
	logic [31:0] aluResult;
	logic [31:0] loadData;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] wbData;
	logic [4:0]  dstReg;
	logic        cmpTrue;
	logic        mduMove;	// mthi/mtlo strobe

	instrDecoder decoder (.instr(instr), .ctrl(ctrl));

	assign imm = ctrl.extSigned ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};
	assign opB = ctrl.aluSrcImm ? imm : rtData;

	aluUnit alu (
		.a(rsData),
		.b(opB),
		.aluOp(ctrl.aluOp),
		.cmpNe(ctrl.cmpNe),
		.result(aluResult),
		.cmpTrue(cmpTrue)
	);

	memAccess mem (
		.clk(clk),
		.rstN(rstN),
		.addr(aluResult),
		.storeData(rtData),
		.write(instrValid && ctrl.memWrite),
		.beOp(ctrl.beOp),
		.deOp(ctrl.deOp),
		.loadData(loadData)
	);

	assign mduMove = instrValid && ((ctrl.mduOp == mduMthi) || (ctrl.mduOp == mduMtlo));

	mulDivUnit mdu (
		.clk(clk),
		.rstN(rstN),
		.start(instrValid && ctrl.mduStart),
		.move(mduMove),
		.mduOp(ctrl.mduOp),
		.rsData(rsData),
		.rtData(rtData),
		.hi(hi),
		.lo(lo),
		.busy(busy)
	);

	////////////////////////////////
	// Writeback select
	////////////////////////////////
	always_comb begin
		case (ctrl.regDst)
			dstRd:   dstReg = instr[15:11];
			dstRa:   dstReg = 5'd31;	// jal link register
			default: dstReg = instr[20:16];
		endcase

		if (ctrl.memToReg == wbSelLink)     wbData = pc + 32'd8;
		else if (ctrl.memToReg == wbSelMem) wbData = loadData;
		else if (ctrl.selMdu)               wbData = (ctrl.mduOp == mduMfhi) ? hi : lo;
		else                                wbData = aluResult;
	end

	// One cycle after issue
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wb          <= '0;
			branchTaken <= 1'b0;
			npcSel      <= npcSeq;
		end else begin
			wb.valid    <= instrValid && ctrl.regWrite;
			wb.regNum   <= dstReg;
			wb.data     <= wbData;
			branchTaken <= instrValid && (ctrl.npcOp == npcBranch) && cmpTrue;
			npcSel      <= instrValid ? ctrl.npcOp : npcSeq;
		end
	end

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder import mipsPkg::*; (
	input  logic [31:0] instr,
	output ctrlT        ctrl
);

	logic [5:0] op;
	logic [5:0] fn;
	logic       rType;

	// Per-instruction recognitions
	logic isAdd, isSub, isAnd, isOr, isSlt, isSltu;
	logic isAddi, isAndi, isOri, isLui;
	logic isLw, isLh, isLb, isSw, isSh, isSb;
	logic isBeq, isBne, isJ, isJal, isJr;
	logic isMult, isMultu, isDiv, isDivu, isMsub;
	logic isMfhi, isMflo, isMthi, isMtlo;

	// Grouped classes
	logic isLoad;
	logic isStore;
	logic rAlu;	// R-type ALU ops writing rd

	assign op    = instr[31:26];
	assign fn    = instr[5:0];
	assign rType = (op == opR);

	////////////////////////////////
	// Recognition
	////////////////////////////////
	assign isAdd   = rType && (fn == fnAdd);
	assign isSub   = rType && (fn == fnSub);
	assign isAnd   = rType && (fn == fnAnd);
	assign isOr    = rType && (fn == fnOr);
	assign isSlt   = rType && (fn == fnSlt);
	assign isSltu  = rType && (fn == fnSltu);
	assign isJr    = rType && (fn == fnJr);
	assign isMult  = rType && (fn == fnMult);
	assign isMultu = rType && (fn == fnMultu);
	assign isDiv   = rType && (fn == fnDiv);
	assign isDivu  = rType && (fn == fnDivu);
	assign isMfhi  = rType && (fn == fnMfhi);
	assign isMflo  = rType && (fn == fnMflo);
	assign isMthi  = rType && (fn == fnMthi);
	assign isMtlo  = rType && (fn == fnMtlo);

	assign isAddi = (op == opAddi);
	assign isAndi = (op == opAndi);
	assign isOri  = (op == opOri);
	assign isLui  = (op == opLui);
	assign isLw   = (op == opLw);
	assign isLh   = (op == opLh);
	assign isLb   = (op == opLb);
	assign isSw   = (op == opSw);
	assign isSh   = (op == opSh);
	assign isSb   = (op == opSb);
	assign isBeq  = (op == opBeq);
	assign isBne  = (op == opBne);
	assign isJ    = (op == opJ);
	assign isJal  = (op == opJal);
	assign isMsub = (op == opMsub);

	assign isLoad  = isLw | isLh | isLb;
	assign isStore = isSw | isSh | isSb;
	assign rAlu    = isAdd | isSub | isAnd | isOr | isSlt | isSltu;

	////////////////////////////////
	// Control word
	////////////////////////////////
	always_comb begin
		ctrl.regDst    = isJal ? dstRa : (rAlu | isMfhi | isMflo) ? dstRd : dstRt;
		ctrl.regWrite  = rAlu | isAddi | isAndi | isOri | isLui | isLoad | isJal | isMfhi | isMflo;
		ctrl.extSigned = isLoad | isStore | isAddi;	// andi/ori stay zero extended
		ctrl.aluSrcImm = isAddi | isAndi | isOri | isLui | isLoad | isStore;

		if (isSub)                ctrl.aluOp = aluSub;
		else if (isOr | isOri)    ctrl.aluOp = aluOr;
		else if (isAnd | isAndi)  ctrl.aluOp = aluAnd;
		else if (isLui)           ctrl.aluOp = aluLui;
		else if (isSlt)           ctrl.aluOp = aluSlt;
		else if (isSltu)          ctrl.aluOp = aluSltu;
		else                      ctrl.aluOp = aluAdd;	// Also address generation

		ctrl.memWrite = isStore;
		ctrl.memToReg = isJal ? wbSelLink : isLoad ? wbSelMem : wbSelAlu;
		ctrl.npcOp    = (isBeq | isBne) ? npcBranch : isJr ? npcReg :
			(isJ | isJal) ? npcJump : npcSeq;
		ctrl.cmpNe    = isBne;

		ctrl.beOp = isSw ? beWord : isSh ? beHalf : isSb ? beByte : beNone;
		ctrl.deOp = isLw ? deWord : isLh ? deHalf : isLb ? deByte : deNone;

		ctrl.mduStart = isMult | isMultu | isDiv | isDivu | isMsub;
		ctrl.selMdu   = isMfhi | isMflo;
		ctrl.mduOp    = isMult ? mduMult : isMultu ? mduMultu : isDiv ? mduDiv :
			isDivu ? mduDivu : isMfhi ? mduMfhi : isMflo ? mduMflo :
			isMthi ? mduMthi : isMtlo ? mduMtlo : isMsub ? mduMsub : mduNone;
	end

endmodule

// ==== logic/memAccess.sv ====
`timescale 1ns/100ps

module memAccess import mipsPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] addr,
	input  logic [31:0] storeData,
	input  logic        write,
	input  beOpT        beOp,
	input  deOpT        deOp,
	output logic [31:0] loadData
);

	logic [31:0] ram [ramWords];

	logic [ramAddrW-1:0] wordIdx;
	logic [1:0]          lane;
	logic [3:0]          byteEn;
	logic [31:0]         wrData;	// Lane-replicated store value
	logic [31:0]         rdWord;
	logic [15:0]         rdHalf;
	logic [7:0]          rdByte;

	assign wordIdx = addr[ramAddrW+1:2];
	assign lane    = addr[1:0];

	////////////////////////////////
	// Store path
	////////////////////////////////
	always_comb begin
		case (beOp)
			beWord: begin
				byteEn = 4'b1111;
				wrData = storeData;
			end
			beHalf: begin
				byteEn = lane[1] ? 4'b1100 : 4'b0011;
				wrData = {2{storeData[15:0]}};
			end
			beByte: begin
				byteEn = 4'b0001 << lane;
				wrData = {4{storeData[7:0]}};
			end
			default: begin
				byteEn = 4'b0000;
				wrData = storeData;
			end
		endcase
	end

	// Simulation start state
	initial begin
		for (int i = 0; i < ramWords; i++) ram[i] = '0;
	end

	always @(posedge clk) begin
		if (rstN && write) begin	// No stores while in reset
			for (int i = 0; i < 4; i++) begin
				if (byteEn[i]) ram[wordIdx][8*i +: 8] <= wrData[8*i +: 8];
			end
		end
	end

	////////////////////////////////
	// Load path
	////////////////////////////////
	assign rdWord = ram[wordIdx];
	assign rdHalf = lane[1] ? rdWord[31:16] : rdWord[15:0];
	assign rdByte = rdWord[{lane, 3'b000} +: 8];

	always_comb begin
		case (deOp)
			deWord:  loadData = rdWord;
			deHalf:  loadData = {{16{rdHalf[15]}}, rdHalf};
			deByte:  loadData = {{24{rdByte[7]}}, rdByte};
			default: loadData = '0;
		endcase
	end

endmodule

// ==== logic/mipsPkg.sv ====
package mipsPkg;

	////////////////////////////////
	// Major opcodes
	////////////////////////////////
	localparam logic [5:0] opR    = 6'h00;	// Function field selects
	localparam logic [5:0] opJ    = 6'h02;
	localparam logic [5:0] opJal  = 6'h03;
	localparam logic [5:0] opBeq  = 6'h04;
	localparam logic [5:0] opBne  = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAndi = 6'h0c;
	localparam logic [5:0] opOri  = 6'h0d;
	localparam logic [5:0] opLui  = 6'h0f;
	localparam logic [5:0] opMsub = 6'h1c;	// Recognized on opcode alone
	localparam logic [5:0] opLb   = 6'h20;
	localparam logic [5:0] opLh   = 6'h21;
	localparam logic [5:0] opLw   = 6'h23;
	localparam logic [5:0] opSb   = 6'h28;
	localparam logic [5:0] opSh   = 6'h29;
	localparam logic [5:0] opSw   = 6'h2b;

	////////////////////////////////
	// R-type function codes
	////////////////////////////////
	localparam logic [5:0] fnJr    = 6'h08;
	localparam logic [5:0] fnMfhi  = 6'h10;
	localparam logic [5:0] fnMthi  = 6'h11;
	localparam logic [5:0] fnMflo  = 6'h12;
	localparam logic [5:0] fnMtlo  = 6'h13;
	localparam logic [5:0] fnMult  = 6'h18;
	localparam logic [5:0] fnMultu = 6'h19;
	localparam logic [5:0] fnDiv   = 6'h1a;
	localparam logic [5:0] fnDivu  = 6'h1b;
	localparam logic [5:0] fnAdd   = 6'h20;
	localparam logic [5:0] fnSub   = 6'h22;
	localparam logic [5:0] fnAnd   = 6'h24;
	localparam logic [5:0] fnOr    = 6'h25;
	localparam logic [5:0] fnSlt   = 6'h2a;
	localparam logic [5:0] fnSltu  = 6'h2b;

	// Writeback source, memToReg field
	localparam logic [1:0] wbSelAlu  = 2'b00;
	localparam logic [1:0] wbSelMem  = 2'b01;
	localparam logic [1:0] wbSelLink = 2'b10;

	////////////////////////////////
	// Sizing
	////////////////////////////////
	localparam int ramWords   = 64;
	localparam int ramAddrW   = $clog2(ramWords);
	localparam int multCycles = 5;
	localparam int divCycles  = 10;
	localparam int mduCntW    = $clog2(divCycles + 1);

	typedef enum logic [2:0] {aluAdd, aluSub, aluOr, aluAnd, aluLui, aluSlt, aluSltu} aluOpT;

	typedef enum logic [3:0] {
		mduNone, mduMult, mduMultu, mduDiv, mduDivu,
		mduMfhi, mduMflo, mduMthi, mduMtlo, mduMsub
	} mduOpT;

	typedef enum logic [1:0] {npcSeq, npcJump, npcBranch, npcReg} npcOpT;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
	typedef enum logic [1:0] {beWord, beHalf, beByte, beNone} beOpT;	// Store width
	typedef enum logic [1:0] {deWord, deHalf, deByte, deNone} deOpT;	// Load kind

	// Decoded control word, 24 bits
	typedef struct packed {
		regDstT     regDst;
		logic       regWrite;
		logic       extSigned;
		logic       aluSrcImm;
		aluOpT      aluOp;
		logic       memWrite;
		logic [1:0] memToReg;
		npcOpT      npcOp;
		logic       cmpNe;
		beOpT       beOp;
		deOpT       deOp;
		logic       mduStart;
		logic       selMdu;
		mduOpT      mduOp;
	} ctrlT;

	typedef struct packed {
		logic        valid;
		logic [4:0]  regNum;
		logic [31:0] data;
	} wbT;

endpackage

// ==== logic/mulDivUnit.sv ====
`timescale 1ns/100ps

module mulDivUnit import mipsPkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  logic        start,
	input  logic        move,
	input  mduOpT       mduOp,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic [31:0] hi,
	output logic [31:0] lo,
	output logic        busy
);

	// Latched operation and operands
	mduOpT       opReg;
	logic [31:0] aReg;
	logic [31:0] bReg;

	logic [mduCntW-1:0] count;	// Remaining busy cycles
	logic               accept;
	logic               done;
	logic               isDivStart;

	logic [63:0] sProd;
	logic [63:0] uProd;
	logic [63:0] msubRes;
	logic [31:0] sQuot;
	logic [31:0] sRem;
	logic [31:0] uQuot;
	logic [31:0] uRem;

	assign busy       = (count != '0);
	assign accept     = start && !busy;	// Start during busy is dropped
	assign done       = (count == mduCntW'(1));
	assign isDivStart = (mduOp == mduDiv) || (mduOp == mduDivu);

	////////////////////////////////
	// Datapath
	////////////////////////////////
	assign sProd   = {{32{aReg[31]}}, aReg} * {{32{bReg[31]}}, bReg};
	assign uProd   = {32'b0, aReg} * {32'b0, bReg};
	assign msubRes = {hi, lo} - sProd;
	assign sQuot   = $signed(aReg) / $signed(bReg);
	assign sRem    = $signed(aReg) % $signed(bReg);
	assign uQuot   = aReg / bReg;
	assign uRem    = aReg % bReg;

	always_ff @(posedge clk) begin
		if (accept) begin
			opReg <= mduOp;
			aReg  <= rsData;
			bReg  <= rtData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			count <= '0;
			hi    <= '0;
			lo    <= '0;
		end else begin
			if (accept) begin
				count <= isDivStart ? mduCntW'(divCycles) : mduCntW'(multCycles);
			end else if (busy) begin
				count <= count - 1'b1;
			end

			if (done) begin	// HI/LO update as busy drops
				case (opReg)
					mduMult:  {hi, lo} <= sProd;
					mduMultu: {hi, lo} <= uProd;
					mduMsub:  {hi, lo} <= msubRes;
					mduDiv: begin
						if (bReg != '0) begin
							hi <= sRem;
							lo <= sQuot;
						end
					end
					mduDivu: begin
						if (bReg != '0) begin
							hi <= uRem;
							lo <= uQuot;
						end
					end
					default: ;
				endcase
			end else if (move) begin
				if (mduOp == mduMthi) hi <= rsData;
				if (mduOp == mduMtlo) lo <= rsData;
			end
		end
	end

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the execCore testbench with Verilator, run it and scan the log
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module execCoreTb -f execCore.f --Mdir obj_dir
./obj_dir/VexecCoreTb | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi
echo "Simulation finished without failure"

// ==== testbench/execCoreTb.sv ====
`timescale 1ns/100ps

module execCoreTb import mipsPkg::*;;

	localparam int clkPeriod = 40;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic [31:0] rs;
		logic [31:0] rt;
		logic        expValid;
		logic [4:0]  expReg;
		logic [31:0] expData;
		logic        expBranch;
		npcOpT       expNpc;
		logic        mdu;	// Wait for busy to drop
	} testT;

	logic        clk;
	logic        rstN;
	logic        instrValid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic [31:0] rsData;
	logic [31:0] rtData;
	wbT          wb;
	logic        branchTaken;
	npcOpT       npcSel;
	logic        busy;

	testT   tests[$];
	integer seed;
	logic   tableReady = 1'b0;
	int     errors = 0;
	int     passed = 0;
	int     failed = 0;

	tbClock #(.period(clkPeriod), .resetCycles(2)) clkGen (.clk(clk), .rstN(rstN));

	execCore uut (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.rsData(rsData),
		.rtData(rtData),
		.wb(wb),
		.branchTaken(branchTaken),
		.npcSel(npcSel),
		.busy(busy)
	);

	// R-type with rs=1, rt=2 in the fields
	function automatic logic [31:0] rInstr(input logic [4:0] rd, input logic [5:0] fn);
		return {opR, 5'd1, 5'd2, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
		input logic [15:0] imm);
		return {op, 5'd1, rt, imm};
	endfunction

	task automatic addTest(input logic [31:0] ins, pcVal, rs, rt, input logic v,
		input logic [4:0] r, input logic [31:0] d, input logic br, input npcOpT npc,
		input logic mdu);
		testT t;
		t.instr     = ins;
		t.pc        = pcVal;
		t.rs        = rs;
		t.rt        = rt;
		t.expValid  = v;
		t.expReg    = r;
		t.expData   = d;
		t.expBranch = br;
		t.expNpc    = npc;
		t.mdu       = mdu;
		tests.push_back(t);
	endtask

	task automatic expectWb(input logic [31:0] ins, rs, rt, input logic [4:0] r,
		input logic [31:0] d);
		addTest(ins, 32'h0, rs, rt, 1'b1, r, d, 1'b0, npcSeq, 1'b0);
	endtask

	task automatic expectNoWb(input logic [31:0] ins, rs, rt, input logic br,
		input npcOpT npc, input logic mdu);
		addTest(ins, 32'h0, rs, rt, 1'b0, 5'd0, 32'h0, br, npc, mdu);
	endtask

	// Expected busy length of each multiply/divide start
	function automatic int busyCyclesFor(input logic [31:0] ins);
		if (ins[31:26] == opR && (ins[5:0] == fnDiv || ins[5:0] == fnDivu)) return divCycles;
		return multCycles;
	endfunction

	//////////////////////////////
	// Stimulus table
	//////////////////////////////
	task automatic buildTable();
		logic [31:0] a;
		logic [31:0] b;
		seed = 32'h0e3d_dc67;
		expectWb(rInstr(5'd3, fnAdd), 32'd5, 32'd7, 5'd3, 32'd12);
		expectWb(rInstr(5'd4, fnSub), 32'd5, 32'd7, 5'd4, 32'hffff_fffe);
		expectWb(rInstr(5'd5, fnAnd), 32'hf0f0_1234, 32'h0ff0_ff00, 5'd5, 32'h00f0_1200);
		expectWb(rInstr(5'd6, fnOr), 32'hf0f0_1234, 32'h0ff0_ff00, 5'd6, 32'hfff0_ff34);
		expectWb(rInstr(5'd7, fnSlt), 32'hffff_ffff, 32'd1, 5'd7, 32'd1);	// -1 < 1
		expectWb(rInstr(5'd8, fnSltu), 32'hffff_ffff, 32'd1, 5'd8, 32'd0);
		expectWb(iInstr(opAddi, 5'd9, 16'hfffc), 32'd10, 32'h0, 5'd9, 32'd6);
		expectWb(iInstr(opAndi, 5'd10, 16'hf00f), 32'hffff_ffff, 32'h0, 5'd10, 32'h0000_f00f);
		expectWb(iInstr(opOri, 5'd11, 16'h8001), 32'h1234_0000, 32'h0, 5'd11, 32'h1234_8001);
		expectWb(iInstr(opLui, 5'd12, 16'habcd), 32'h0, 32'h0, 5'd12, 32'habcd_0000);

		// Lane writes into the word at 0x10
		expectNoWb(iInstr(opSw, 5'd2, 16'h0010), 32'h0, 32'h1122_3344, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'h1122_3344);
		expectNoWb(iInstr(opSb, 5'd2, 16'h0010), 32'h0, 32'hffff_ffa0, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'h1122_33a0);
		expectNoWb(iInstr(opSb, 5'd2, 16'h0011), 32'h0, 32'hffff_ffa1, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'h1122_a1a0);
		expectNoWb(iInstr(opSb, 5'd2, 16'h0012), 32'h0, 32'hffff_ffa2, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'h11a2_a1a0);
		expectNoWb(iInstr(opSb, 5'd2, 16'h0013), 32'h0, 32'hffff_ffa3, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'ha3a2_a1a0);
		expectNoWb(iInstr(opSh, 5'd2, 16'h0010), 32'h0, 32'hffff_b0b1, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'ha3a2_b0b1);
		expectNoWb(iInstr(opSh, 5'd2, 16'h0012), 32'h0, 32'hffff_c0c1, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'hc0c1_b0b1);
		expectWb(iInstr(opLb, 5'd14, 16'h0003), 32'h10, 32'h0, 5'd14, 32'hffff_ffc0);
		expectWb(iInstr(opLb, 5'd14, 16'h0010), 32'h0, 32'h0, 5'd14, 32'hffff_ffb1);
		expectWb(iInstr(opLh, 5'd15, 16'h0012), 32'h0, 32'h0, 5'd15, 32'hffff_c0c1);
		expectWb(iInstr(opLh, 5'd15, 16'h0010), 32'h0, 32'h0, 5'd15, 32'hffff_b0b1);

		// Branches and jumps
		expectNoWb(iInstr(opBeq, 5'd2, 16'h0004), 32'd5, 32'd5, 1'b1, npcBranch, 1'b0);
		expectNoWb(iInstr(opBeq, 5'd2, 16'h0004), 32'd5, 32'd6, 1'b0, npcBranch, 1'b0);
		expectNoWb(iInstr(opBne, 5'd2, 16'h0004), 32'd5, 32'd6, 1'b1, npcBranch, 1'b0);
		expectNoWb(iInstr(opBne, 5'd2, 16'h0004), 32'd5, 32'd5, 1'b0, npcBranch, 1'b0);
		expectNoWb({opJ, 26'h000_0040}, 32'h0, 32'h0, 1'b0, npcJump, 1'b0);
		expectNoWb(rInstr(5'd0, fnJr), 32'h100, 32'h0, 1'b0, npcReg, 1'b0);
		addTest({opJal, 26'h000_0040}, 32'h400, 32'h0, 32'h0, 1'b1, 5'd31, 32'h400 + 32'd8,
			1'b0, npcJump, 1'b0);

		// Multiply and divide, read back through mfhi/mflo
		expectNoWb(rInstr(5'd0, fnMult), 32'hffff_fffe, 32'd3, 1'b0, npcSeq, 1'b1);
		expectWb(rInstr(5'd20, fnMfhi), 32'h0, 32'h0, 5'd20, 32'hffff_ffff);
		expectWb(rInstr(5'd21, fnMflo), 32'h0, 32'h0, 5'd21, 32'hffff_fffa);	// -6
		expectNoWb(rInstr(5'd0, fnMultu), 32'hffff_fffe, 32'd3, 1'b0, npcSeq, 1'b1);
		expectWb(rInstr(5'd20, fnMfhi), 32'h0, 32'h0, 5'd20, 32'h0000_0002);
		expectWb(rInstr(5'd21, fnMflo), 32'h0, 32'h0, 5'd21, 32'hffff_fffa);
		expectNoWb(rInstr(5'd0, fnDiv), 32'hffff_fff9, 32'd2, 1'b0, npcSeq, 1'b1);
		expectWb(rInstr(5'd20, fnMfhi), 32'h0, 32'h0, 5'd20, 32'hffff_ffff);	// Rem -1
		expectWb(rInstr(5'd21, fnMflo), 32'h0, 32'h0, 5'd21, 32'hffff_fffd);	// Quot -3
		expectNoWb(rInstr(5'd0, fnDivu), 32'hffff_fff9, 32'd2, 1'b0, npcSeq, 1'b1);
		expectWb(rInstr(5'd20, fnMfhi), 32'h0, 32'h0, 5'd20, 32'h0000_0001);
		expectWb(rInstr(5'd21, fnMflo), 32'h0, 32'h0, 5'd21, 32'h7fff_fffc);

		// Moves, then msub borrows across the HI:LO pair
		expectNoWb(rInstr(5'd0, fnMthi), 32'd1, 32'h0, 1'b0, npcSeq, 1'b0);
		expectNoWb(rInstr(5'd0, fnMtlo), 32'd5, 32'h0, 1'b0, npcSeq, 1'b0);
		expectWb(rInstr(5'd22, fnMfhi), 32'h0, 32'h0, 5'd22, 32'd1);
		expectWb(rInstr(5'd23, fnMflo), 32'h0, 32'h0, 5'd23, 32'd5);
		expectNoWb({opMsub, 26'h0}, 32'd3, 32'd5, 1'b0, npcSeq, 1'b1);
		expectWb(rInstr(5'd22, fnMfhi), 32'h0, 32'h0, 5'd22, 32'h0);
		expectWb(rInstr(5'd23, fnMflo), 32'h0, 32'h0, 5'd23, 32'hffff_fff6);

		// Undefined opcode shaped like a store to 0x10
		expectNoWb({6'h3f, 5'd0, 5'd13, 16'h0010}, 32'h0, 32'hffff_ffff, 1'b0, npcSeq, 1'b0);
		expectWb(iInstr(opLw, 5'd13, 16'h0010), 32'h0, 32'h0, 5'd13, 32'hc0c1_b0b1);

		for (int i = 0; i < 10; i++) begin
			a = $random(seed);
			b = $random(seed);
			case (i % 3)
				0: expectWb(rInstr(5'd16, fnAdd), a, b, 5'd16, a + b);
				1: expectWb(rInstr(5'd17, fnSub), a, b, 5'd17, a - b);
				default: expectWb(rInstr(5'd18, fnSlt), a, b, 5'd18,
					{31'b0, $signed(a) < $signed(b)});
			endcase
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got, expected);
		errors++;
		$display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, expected);
	endtask

	task automatic runTest(input int idx);
		testT t;
		int   errorsBefore;
		int   waitCnt;
		int   expCycles;
		t            = tests[idx];
		errorsBefore = errors;
		expCycles    = busyCyclesFor(t.instr);
		@(posedge clk);
		instrValid <= 1'b1;
		instr      <= t.instr;
		pc         <= t.pc;
		rsData     <= t.rs;
		rtData     <= t.rt;
		@(posedge clk);	// Issue edge
		instrValid <= 1'b0;
		@(negedge clk);
		if (wb.valid !== t.expValid) reportMismatch("wb.valid", 32'(wb.valid), 32'(t.expValid));
		if (t.expValid && wb.regNum !== t.expReg)
			reportMismatch("wb.regNum", 32'(wb.regNum), 32'(t.expReg));
		if (t.expValid && wb.data !== t.expData) reportMismatch("wb.data", wb.data, t.expData);
		if (branchTaken !== t.expBranch)
			reportMismatch("branchTaken", 32'(branchTaken), 32'(t.expBranch));
		if (npcSel !== t.expNpc) reportMismatch("npcSel", 32'(npcSel), 32'(t.expNpc));
		if (t.mdu) begin
			if (!busy) begin
				errors++;
				$display("Test %0d: busy did not rise after a multiply/divide start", idx);
			end
			waitCnt = 0;
			while (busy && waitCnt <= divCycles) begin
				@(negedge clk);
				waitCnt++;
			end
			if (busy) begin
				errors++;
				$display("Test %0d: busy still high after %0d cycles", idx, waitCnt);
			end else if (waitCnt != expCycles) begin
				reportMismatch("busy length", 32'(waitCnt), 32'(expCycles));
			end
		end
		if (errors == errorsBefore) begin
			passed++;
			$display("Test %0d passed, instr %h", idx, t.instr);
		end else begin
			failed++;
			$display("Test %0d failed, instr %h", idx, t.instr);
		end
	endtask

	//////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////
	initial begin
		instrValid = 1'b0;
		instr      = '0;
		pc         = '0;
		rsData     = '0;
		rtData     = '0;
		buildTable();
		tableReady = 1'b1;
		@(posedge rstN);
		@(negedge clk);
		if (wb.valid !== 1'b0) reportMismatch("wb.valid", 32'(wb.valid), 32'h0);
		if (branchTaken !== 1'b0) reportMismatch("branchTaken", 32'(branchTaken), 32'h0);
		if (busy !== 1'b0) reportMismatch("busy", 32'(busy), 32'h0);
		if (npcSel !== npcSeq) reportMismatch("npcSel", 32'(npcSel), 32'(npcSeq));
		for (int i = 0; i < tests.size(); i++) runTest(i);
		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			tests.size(), passed, failed, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		wait (tableReady);
		#(tests.size() * (divCycles + 4) * clkPeriod);
		$display("Watchdog expired before all tests finished");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== testbench/execCore_properties.sv ====
`timescale 1ns/100ps

module execCoreProperties import mipsPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instrValid,
	input logic busy,
	input wbT   wb
);

	logic [7:0] busyLen;	// Cycles busy has been high

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busyLen <= '0;
		end else begin
			busyLen <= busy ? busyLen + 8'd1 : 8'd0;
		end
	end

	//////////////////////////////
	// Issue and busy rules
	//////////////////////////////
	noIssueWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
		busy |-> !instrValid)
		else $error("instruction issued while the multiply/divide unit is busy");

	wbAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
		wb.valid |-> $past(instrValid))
		else $error("writeback valid without an issue in the previous cycle");

	// Busy length must match one of the two unit latencies
	busyLength: assert property (@(posedge clk) disable iff (!rstN)
		$fell(busy) |-> (busyLen == 8'(multCycles)) || (busyLen == 8'(divCycles)))
		else $error("busy stayed high for %0d cycles", busyLen);

endmodule

bind execCore execCoreProperties props (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.busy(busy),
	.wb(wb)
);

// ==== testbench/tbClock.sv ====
`timescale 1ns/100ps

module tbClock #(
	parameter int period      = 40,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk  = 1'b0;
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;	// Release on a rising edge
	end

	always #(period / 2) clk = ~clk;

endmodule
